// ==== dv/hartTb.sv ====
// hart testbench
// memory models, program encoders and directed tests for the three-stage hart
`timescale 1ns/1ps
`include "hart_params.svh"

module hartTb;

  logic clk, rstN, dataReady, illegalInstr, memReadE, memWriteE, randomReady, sentinelSeen;
  hartPkg::wordT  pcF, memAdrE, writeDataE, readDataE;
  hartPkg::instrT instrF;
  hartPkg::instrT imem [0:255];
  hartPkg::wordT  dmem [0:255];
  int writeCount [0:255];
  int progLen, illegalCount, errors, checks, testErrStart;
  int loadCount, waitCount;
  logic [31:0] lcgState;

  pipelinedHart dut0 (.*);

  // combinational memory ports
  assign instrF    = imem[pcF[9:2]];
  assign readDataE = dmem[memAdrE[9:2]];

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////
  // memory model and monitors
  //////////////////////////////
  // an access completes on the edge where its strobe and dataReady are high
  always @(posedge clk) begin
    if (rstN) begin
      if (memWriteE && dataReady) begin
        dmem[memAdrE[9:2]] <= writeDataE;
        writeCount[memAdrE[9:2]] = writeCount[memAdrE[9:2]] + 1;
        if (memAdrE == 32'h3FC) sentinelSeen = 1'b1;
      end
      if (memReadE && dataReady) loadCount = loadCount + 1;
      // cycles in which a strobe waits on dataReady
      if ((memReadE || memWriteE) && !dataReady) waitCount = waitCount + 1;
      if (illegalInstr) illegalCount = illegalCount + 1;
    end
  end

  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState;
  endfunction

  // ready is low on about three cycles in four in random mode
  always @(negedge clk) begin : readyDrive
    logic [31:0] rnd;
    rnd = lcgNext();
    dataReady = !randomReady || (rnd[17:16] == 2'b00);
  end

  //////////////////////////////
  // instruction encoders
  //////////////////////////////
  function automatic hartPkg::instrT iType(logic [31:0] imm, hartPkg::regIdxT rs1,
                                           logic [2:0] f3, hartPkg::regIdxT rd, logic [6:0] op);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction
  function automatic hartPkg::instrT addi(hartPkg::regIdxT rd, hartPkg::regIdxT rs1, int imm);
    return iType(imm, rs1, 3'b000, rd, `HART_OP_IMM);
  endfunction
  function automatic hartPkg::instrT lw(hartPkg::regIdxT rd, hartPkg::regIdxT rs1, int imm);
    return iType(imm, rs1, 3'b010, rd, `HART_OP_LOAD);
  endfunction
  function automatic hartPkg::instrT sw(hartPkg::regIdxT rs2, hartPkg::regIdxT rs1,
                                        logic [31:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `HART_OP_STORE};
  endfunction
  function automatic hartPkg::instrT rType(logic [6:0] f7, logic [2:0] f3, hartPkg::regIdxT rd,
                                           hartPkg::regIdxT rs1, hartPkg::regIdxT rs2);
    return {f7, rs2, rs1, f3, rd, `HART_OP_REG};
  endfunction
  function automatic hartPkg::instrT lui(hartPkg::regIdxT rd, logic [19:0] imm);
    return {imm, rd, `HART_OP_LUI};
  endfunction
  function automatic hartPkg::instrT branch(logic [2:0] f3, hartPkg::regIdxT rs1,
                                            hartPkg::regIdxT rs2, logic [31:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `HART_OP_BRANCH};
  endfunction
  function automatic hartPkg::instrT jal(hartPkg::regIdxT rd, logic [31:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, `HART_OP_JAL};
  endfunction

  // untouched data words carry their own byte address
  function automatic hartPkg::wordT fillWord(int adr);
    return 32'hF00D_0000 | adr;
  endfunction

  //////////////////////////////
  // compare tasks
  //////////////////////////////
  task automatic compareWord(string name, hartPkg::wordT exp, hartPkg::wordT act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask
  task automatic compareCount(string name, int exp, int act);
    checks++;
    if (exp != act) begin
      errors++;
      $display("ERR t=%0t %s expected %0d actual %0d", $time, name, exp, act);
    end
  endtask
  task automatic checkMem(int adr, hartPkg::wordT exp);
    compareWord($sformatf("dmem[%h]", adr), exp, dmem[adr >> 2]);
  endtask

  //////////////////////////////
  // program handling
  //////////////////////////////
  task automatic emit(hartPkg::instrT w);
    imem[progLen] = w;
    progLen++;
  endtask

  // reset goes low first so the old program cannot run on the new memories
  task automatic beginTest();
    @(negedge clk);
    rstN = 1'b0;
    testErrStart = errors;
    progLen = 0;
    illegalCount = 0;
    loadCount = 0;
    waitCount = 0;
    sentinelSeen = 1'b0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = `HART_NOP;
      dmem[i] <= fillWord(i * 4);
      writeCount[i] = 0;
    end
  endtask

  // sentinel store, self-loop, release reset, then wait for the sentinel
  task automatic runProgram(string name, int expIllegal);
    int cycles;
    emit(sw(5'd0, 5'd0, 32'h3FC));
    emit(jal(5'd0, 0));
    repeat (5) @(negedge clk);
    rstN = 1'b1;
    cycles = 0;
    while (!sentinelSeen && cycles < 2000) begin
      @(negedge clk);
      cycles++;
    end
    if (!sentinelSeen) begin
      errors++;
      $display("%s timed out waiting for the sentinel store", name);
    end
    compareCount("illegalInstr pulses", expIllegal, illegalCount);
  endtask

  task automatic endTest(string name);
    $display("test %s done, %0d errors", name, errors - testErrStart);
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////
  task automatic testArith();
    beginTest();
    emit(lui(5'd1, 20'h12345));
    emit(addi(5'd2, 5'd0, 100));
    emit(addi(5'd3, 5'd0, -7));
    emit(addi(5'd7, 5'd1, 32'h678));
    emit(rType(7'h00, 3'b000, 5'd4, 5'd2, 5'd3));
    emit(rType(7'h20, 3'b000, 5'd5, 5'd3, 5'd2));
    emit(rType(7'h00, 3'b111, 5'd6, 5'd7, 5'd3));
    emit(rType(7'h00, 3'b110, 5'd8, 5'd7, 5'd3));
    emit(rType(7'h00, 3'b100, 5'd9, 5'd7, 5'd2));
    emit(rType(7'h00, 3'b010, 5'd10, 5'd3, 5'd2));
    emit(rType(7'h00, 3'b010, 5'd11, 5'd2, 5'd3));
    for (int r = 1; r <= 11; r++) emit(sw(r[4:0], 5'd0, 32'h100 + 4 * r));
    runProgram("arith", 0);
    checkMem(32'h104, 32'h1234_5000);
    checkMem(32'h108, 32'd100);
    checkMem(32'h10C, -32'sd7);
    checkMem(32'h110, 32'd93);
    checkMem(32'h114, -32'sd107);
    checkMem(32'h118, 32'h1234_5678 & 32'hFFFF_FFF9);
    checkMem(32'h11C, 32'h1234_5678);
    checkMem(32'h120, 32'h1234_5678 | 32'hFFFF_FFF9);
    checkMem(32'h124, 32'h1234_5678 ^ 32'd100);
    checkMem(32'h128, 32'd1);
    checkMem(32'h12C, 32'd0);
    endTest("arith");
  endtask

  task automatic testChain();
    beginTest();
    emit(addi(5'd1, 5'd0, 5));
    emit(rType(7'h00, 3'b000, 5'd2, 5'd1, 5'd1));
    emit(rType(7'h20, 3'b000, 5'd3, 5'd2, 5'd1));
    emit(rType(7'h00, 3'b100, 5'd4, 5'd3, 5'd2));
    emit(addi(5'd5, 5'd4, -20));
    emit(rType(7'h00, 3'b010, 5'd6, 5'd5, 5'd4));
    emit(rType(7'h00, 3'b110, 5'd7, 5'd6, 5'd5));
    emit(rType(7'h00, 3'b111, 5'd8, 5'd7, 5'd4));
    for (int r = 2; r <= 8; r++) emit(sw(r[4:0], 5'd0, 32'h140 + 4 * r));
    runProgram("chain", 0);
    checkMem(32'h148, 32'd10);
    checkMem(32'h14C, 32'd5);
    checkMem(32'h150, 32'd15);
    checkMem(32'h154, -32'sd5);
    checkMem(32'h158, 32'd1);
    checkMem(32'h15C, -32'sd5);
    checkMem(32'h160, 32'd11);
    endTest("chain");
  endtask

  task automatic buildLoadStore();
    emit(addi(5'd1, 5'd0, 32'h2A5));
    emit(sw(5'd1, 5'd0, 32'h200));
    emit(lw(5'd2, 5'd0, 32'h200));
    emit(addi(5'd3, 5'd2, 1));
    emit(sw(5'd3, 5'd0, 32'h204));
    emit(addi(5'd0, 5'd0, 55));
    emit(sw(5'd0, 5'd0, 32'h208));
    emit(rType(7'h00, 3'b000, 5'd4, 5'd0, 5'd3));
    emit(sw(5'd4, 5'd0, 32'h20C));
  endtask

  // the program holds exactly one load
  task automatic checkLoadStore();
    checkMem(32'h200, 32'h2A5);
    checkMem(32'h204, 32'h2A6);
    checkMem(32'h208, 32'd0);
    checkMem(32'h20C, 32'h2A6);
    compareCount("completed loads", 1, loadCount);
  endtask

  task automatic testLoadStore();
    beginTest();
    buildLoadStore();
    runProgram("loadStore", 0);
    checkLoadStore();
    endTest("loadStore");
  endtask

  task automatic testControl();
    int jalAdr;
    beginTest();
    emit(addi(5'd1, 5'd0, 3));
    emit(addi(5'd2, 5'd0, 3));
    emit(addi(5'd3, 5'd0, 4));
    emit(branch(3'b000, 5'd1, 5'd2, 12));
    emit(sw(5'd1, 5'd0, 32'h300));
    emit(sw(5'd1, 5'd0, 32'h304));
    emit(addi(5'd10, 5'd0, 1));
    emit(sw(5'd10, 5'd0, 32'h308));
    emit(branch(3'b001, 5'd1, 5'd2, 12));
    emit(sw(5'd1, 5'd0, 32'h30C));
    emit(branch(3'b001, 5'd1, 5'd3, 12));
    emit(sw(5'd1, 5'd0, 32'h310));
    emit(sw(5'd1, 5'd0, 32'h314));
    jalAdr = progLen * 4;
    emit(jal(5'd5, 12));
    emit(sw(5'd1, 5'd0, 32'h318));
    emit(sw(5'd1, 5'd0, 32'h31C));
    emit(sw(5'd5, 5'd0, 32'h320));
    emit(branch(3'b000, 5'd1, 5'd3, 8));
    emit(sw(5'd3, 5'd0, 32'h324));
    runProgram("control", 0);
    // wrong-path slots keep their fill
    checkMem(32'h300, fillWord(32'h300));
    checkMem(32'h304, fillWord(32'h304));
    checkMem(32'h308, 32'd1);
    checkMem(32'h30C, 32'd3);
    checkMem(32'h310, fillWord(32'h310));
    checkMem(32'h314, fillWord(32'h314));
    checkMem(32'h318, fillWord(32'h318));
    checkMem(32'h31C, fillWord(32'h31C));
    checkMem(32'h320, jalAdr + 4);
    checkMem(32'h324, 32'd4);
    endTest("control");
  endtask

  task automatic testBackPressure();
    beginTest();
    buildLoadStore();
    randomReady = 1'b1;
    runProgram("backPressure", 0);
    randomReady = 1'b0;
    checks++;
    if (waitCount == 0) begin
      errors++;
      $display("backPressure never stretched a data access");
    end
    checkLoadStore();
    for (int a = 32'h200; a <= 32'h20C; a += 4) begin
      compareCount($sformatf("writes to %h", a), 1, writeCount[a >> 2]);
    end
    endTest("backPressure");
  endtask

  task automatic testIllegal();
    beginTest();
    emit(addi(5'd1, 5'd0, 7));
    emit(32'hFFFF_FFFF);
    emit(addi(5'd2, 5'd1, 1));
    // slli encoding, not supported here
    emit(32'h0000_1013);
    emit(rType(7'h00, 3'b000, 5'd3, 5'd2, 5'd1));
    for (int r = 1; r <= 3; r++) emit(sw(r[4:0], 5'd0, 32'h380 + 4 * r));
    runProgram("illegal", 2);
    checkMem(32'h384, 32'd7);
    checkMem(32'h388, 32'd8);
    checkMem(32'h38C, 32'd15);
    endTest("illegal");
  endtask

  initial begin
    rstN = 1'b0;
    dataReady = 1'b1;
    randomReady = 1'b0;
    sentinelSeen = 1'b0;
    lcgState = 32'd17366;
    errors = 0;
    checks = 0;
    testArith();
    testChain();
    testLoadStore();
    testControl();
    testBackPressure();
    testIllegal();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== dv/hart_checker.sv ====
// memory port checker
// concurrent assertions on the data and instruction ports of the hart
`timescale 1ns/1ps

module hart_checker (
  input logic          clk,
  input logic          rstN,
  input hartPkg::wordT pcF,
  input hartPkg::wordT memAdrE,
  input hartPkg::wordT writeDataE,
  input logic          memReadE,
  input logic          memWriteE,
  input logic          dataReady
);

  // one strobe at a time
  noDoubleStrobe: assert property (@(posedge clk) disable iff (!rstN)
    !(memReadE && memWriteE)) else $error("read and write strobes high together");

  // fetch address on a word boundary
  pcAligned: assert property (@(posedge clk) disable iff (!rstN)
    pcF[1:0] == 2'b00) else $error("fetch address not word aligned");

  // pipe starts with bubbles
  quietAfterReset: assert property (@(posedge clk)
    $rose(rstN) |-> (!memReadE && !memWriteE)) else $error("strobe high right after reset");

  // stretched access holds still
  holdWhileWait: assert property (@(posedge clk) disable iff (!rstN)
    ((memReadE || memWriteE) && !dataReady) |=>
      ($stable(memReadE) && $stable(memWriteE) && $stable(memAdrE) && $stable(writeDataE)))
    else $error("data request changed while dataReady was low");

endmodule

bind pipelinedHart hart_checker chk0 (.*);

// ==== hart.f ====
+incdir+source
source/hartPkg.sv
source/ifu.sv
source/decoder.sv
source/regfile.sv
source/ieu.sv
source/hazard.sv
source/pipelinedHart.sv
dv/hart_checker.sv
dv/hartTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the hart testbench with Verilator
# the run fails if the log holds the fail message or lacks the pass message
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f hart.f --top-module hartTb -o hartSim \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/hartSim > sim.log 2>&1
grep -q "TEST FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "no pass line in sim.log"; exit 1; }
echo "simulation passed"
exit 0

// ==== source/decoder.sv ====
// instruction decoder
// turns one RV32I word into control fields and a sign-extended immediate
`timescale 1ns/1ps
`include "hart_params.svh"

module decoder (
  input  hartPkg::instrT  instrD,
  output hartPkg::regIdxT rs1D,
  output hartPkg::regIdxT rs2D,
  output hartPkg::regIdxT rdD,
  output hartPkg::wordT   immD,
  output hartPkg::aluOpT  aluOpD,
  output logic            aluSrcImmD,
  output logic            regWriteD,
  output logic            memReadD,
  output logic            memWriteD,
  output logic            branchD,
  output logic            branchNeD,
  output logic            jumpD,
  output logic            illegalD
);

  logic [6:0]    opcode;
  logic [2:0]    funct3;
  logic [6:0]    funct7;
  hartPkg::wordT immI;
  hartPkg::wordT immS;
  hartPkg::wordT immB;
  hartPkg::wordT immU;
  hartPkg::wordT immJ;

  assign opcode = instrD[6:0];
  assign funct3 = instrD[14:12];
  assign funct7 = instrD[31:25];

  // register fields sit at fixed positions in every format
  assign rs1D = instrD[19:15];
  assign rs2D = instrD[24:20];
  assign rdD  = instrD[11:7];

  //////////////////////////////
  // immediate formats
  //////////////////////////////
  assign immI = {{20{instrD[31]}}, instrD[31:20]};
  assign immS = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
  assign immB = {{19{instrD[31]}}, instrD[31], instrD[7], instrD[30:25], instrD[11:8], 1'b0};
  assign immU = {instrD[31:12], 12'b0};
  assign immJ = {{11{instrD[31]}}, instrD[31], instrD[19:12], instrD[20], instrD[30:21], 1'b0};

  //////////////////////////////
  // control decode
  //////////////////////////////
  // defaults are all zero so an unknown word leaves no write or memory control set
  always_comb begin
    immD       = '0;
    aluOpD     = `HART_ALU_ADD;
    aluSrcImmD = 1'b0;
    regWriteD  = 1'b0;
    memReadD   = 1'b0;
    memWriteD  = 1'b0;
    branchD    = 1'b0;
    branchNeD  = 1'b0;
    jumpD      = 1'b0;
    illegalD   = 1'b0;
    case (opcode)
      `HART_OP_LUI: begin
        immD       = immU;
        aluOpD     = `HART_ALU_PASSB;
        aluSrcImmD = 1'b1;
        regWriteD  = 1'b1;
      end
      `HART_OP_IMM: begin
        // only addi among the immediate ops
        if (funct3 == 3'b000) begin
          immD       = immI;
          aluSrcImmD = 1'b1;
          regWriteD  = 1'b1;
        end else begin
          illegalD = 1'b1;
        end
      end
      `HART_OP_REG: begin
        regWriteD = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: aluOpD = `HART_ALU_ADD;
          {7'b0100000, 3'b000}: aluOpD = `HART_ALU_SUB;
          {7'b0000000, 3'b111}: aluOpD = `HART_ALU_AND;
          {7'b0000000, 3'b110}: aluOpD = `HART_ALU_OR;
          {7'b0000000, 3'b100}: aluOpD = `HART_ALU_XOR;
          {7'b0000000, 3'b010}: aluOpD = `HART_ALU_SLT;
          default: begin
            regWriteD = 1'b0;
            illegalD  = 1'b1;
          end
        endcase
      end
      `HART_OP_LOAD: begin
        // word loads only
        if (funct3 == 3'b010) begin
          immD       = immI;
          aluSrcImmD = 1'b1;
          regWriteD  = 1'b1;
          memReadD   = 1'b1;
        end else begin
          illegalD = 1'b1;
        end
      end
      `HART_OP_STORE: begin
        if (funct3 == 3'b010) begin
          immD       = immS;
          aluSrcImmD = 1'b1;
          memWriteD  = 1'b1;
        end else begin
          illegalD = 1'b1;
        end
      end
      `HART_OP_BRANCH: begin
        // beq and bne share the compare, funct3[0] inverts it
        if (funct3[2:1] == 2'b00) begin
          immD      = immB;
          branchD   = 1'b1;
          branchNeD = funct3[0];
        end else begin
          illegalD = 1'b1;
        end
      end
      `HART_OP_JAL: begin
        immD      = immJ;
        jumpD     = 1'b1;
        regWriteD = 1'b1;
      end
      default: illegalD = 1'b1;
    endcase
  end

endmodule

// ==== source/hartPkg.sv ====
// hart package
// shared vector types for the three-stage RV32I hart
package hartPkg;

  //////////////////////////////
  // datapath widths
  //////////////////////////////

  // data or address word
  typedef logic [31:0] wordT;

  // raw instruction word
  typedef logic [31:0] instrT;

  // architectural register index
  typedef logic [4:0] regIdxT;

  //////////////////////////////
  // control encodings
  //////////////////////////////

  // ALU operation select, values in hart_params.svh
  typedef logic [2:0] aluOpT;

endpackage

// ==== source/hart_params.svh ====
// hart constants
// major opcodes, ALU operation codes, reset PC and the bubble encoding
`ifndef HART_PARAMS_SVH
`define HART_PARAMS_SVH

// PC after reset
`define HART_RESET_PC 32'h0000_0000
// addi x0, x0, 0 used as a pipeline bubble
`define HART_NOP 32'h0000_0013

// RV32I major opcodes
`define HART_OP_LUI 7'b0110111
`define HART_OP_IMM 7'b0010011
`define HART_OP_REG 7'b0110011
`define HART_OP_LOAD 7'b0000011
`define HART_OP_STORE 7'b0100011
`define HART_OP_BRANCH 7'b1100011
`define HART_OP_JAL 7'b1101111

// ALU operation codes
`define HART_ALU_ADD 3'd0
`define HART_ALU_SUB 3'd1
`define HART_ALU_AND 3'd2
`define HART_ALU_OR 3'd3
`define HART_ALU_XOR 3'd4
`define HART_ALU_SLT 3'd5
`define HART_ALU_PASSB 3'd6

`endif

// ==== source/hazard.sv ====
// hazard unit
// global stall and flush control, stall always wins over flush
`timescale 1ns/1ps

module hazard (
  input  logic pcSrcE,
  input  logic memWaitE,
  output logic stallF,
  output logic stallD,
  output logic stallE,
  output logic flushD,
  output logic flushE
);

  // a stretched data access freezes the whole pipe
  assign stallF = memWaitE;
  assign stallD = memWaitE;
  assign stallE = memWaitE;

  // taken control transfer squashes the two younger instructions
  // held off until the stall clears
  assign flushD = pcSrcE && !memWaitE;
  assign flushE = pcSrcE && !memWaitE;

endmodule

// ==== source/ieu.sv ====
// integer execution unit
// decode and register read in D, then ALU, branch, data access and writeback in E
`timescale 1ns/1ps
`include "hart_params.svh"

module ieu (
  input  logic           clk,
  input  logic           rstN,
  input  hartPkg::instrT instrD,
  input  hartPkg::wordT  pcD,
  input  hartPkg::wordT  readDataE,
  input  logic           dataReady,
  input  logic           stallE,
  input  logic           flushE,
  output hartPkg::wordT  pcTargetE,
  output hartPkg::wordT  memAdrE,
  output hartPkg::wordT  writeDataE,
  output logic           pcSrcE,
  output logic           memWaitE,
  output logic           memReadE,
  output logic           memWriteE,
  output logic           illegalInstr
);

  // decode stage
  hartPkg::regIdxT rs1D, rs2D, rdD;
  hartPkg::wordT   immD, rd1D, rd2D;
  hartPkg::aluOpT  aluOpD;
  logic            aluSrcImmD, regWriteD, memReadD, memWriteD;
  logic            branchD, branchNeD, jumpD, illegalD;

  // execute stage
  hartPkg::regIdxT rdE;
  hartPkg::wordT   immE, rd1E, rd2E, pcE;
  hartPkg::wordT   srcBE, aluResultE, resultE;
  hartPkg::aluOpT  aluOpE;
  logic            aluSrcImmE, regWriteE, branchE, branchNeE, jumpE, illegalE;
  logic            takenE, regWriteGatedE;

  decoder dec (.*);

  regfile rf (
    .clk       (clk),
    .rstN      (rstN),
    .rs1D      (rs1D),
    .rs2D      (rs2D),
    .rdE       (rdE),
    .resultE   (resultE),
    .regWriteE (regWriteGatedE),
    .rd1D      (rd1D),
    .rd2D      (rd2D)
  );

  //////////////////////////////
  // D-to-E register
  //////////////////////////////
  // control bits, a flush leaves a bubble
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      {regWriteE, memReadE, memWriteE, branchE, branchNeE, jumpE, illegalE} <= '0;
    end else if (flushE) begin
      {regWriteE, memReadE, memWriteE, branchE, branchNeE, jumpE, illegalE} <= '0;
    end else if (!stallE) begin
      {regWriteE, memReadE, memWriteE} <= {regWriteD, memReadD, memWriteD};
      {branchE, branchNeE, jumpE, illegalE} <= {branchD, branchNeD, jumpD, illegalD};
    end
  end

  // operands and fields, only meaningful alongside the controls above
  always_ff @(posedge clk) begin
    if (!stallE) begin
      rd1E       <= rd1D;
      rd2E       <= rd2D;
      immE       <= immD;
      rdE        <= rdD;
      aluOpE     <= aluOpD;
      aluSrcImmE <= aluSrcImmD;
      pcE        <= pcD;
    end
  end

  //////////////////////////////
  // ALU
  //////////////////////////////
  assign srcBE = aluSrcImmE ? immE : rd2E;

  always_comb begin
    case (aluOpE)
      `HART_ALU_SUB:   aluResultE = rd1E - srcBE;
      `HART_ALU_AND:   aluResultE = rd1E & srcBE;
      `HART_ALU_OR:    aluResultE = rd1E | srcBE;
      `HART_ALU_XOR:   aluResultE = rd1E ^ srcBE;
      `HART_ALU_SLT:   aluResultE = {31'b0, $signed(rd1E) < $signed(srcBE)};
      `HART_ALU_PASSB: aluResultE = srcBE;
      default:         aluResultE = rd1E + srcBE;
    endcase
  end

  //////////////////////////////
  // branch and memory
  //////////////////////////////
  // memory access stretches while dataReady is low
  assign memWaitE   = (memReadE || memWriteE) && !dataReady;
  assign memAdrE    = aluResultE;
  assign writeDataE = rd2E;

  assign takenE    = jumpE || (branchE && ((rd1E == rd2E) != branchNeE));
  assign pcTargetE = pcE + immE;
  assign pcSrcE    = takenE && !memWaitE;

  // writeback picks load data, link address or ALU result
  always_comb begin
    if (memReadE) begin
      resultE = readDataE;
    end else if (jumpE) begin
      resultE = pcE + 32'd4;
    end else begin
      resultE = aluResultE;
    end
  end

  assign regWriteGatedE = regWriteE && !memWaitE;

  // one pulse per illegal word leaving E
  assign illegalInstr = illegalE && !stallE;

endmodule

// ==== source/ifu.sv ====
// instruction fetch unit
// holds the PC, picks the next PC and fills the F-to-D instruction register
`timescale 1ns/1ps
`include "hart_params.svh"

module ifu (
  input  logic           clk,
  input  logic           rstN,
  input  hartPkg::instrT instrF,
  input  hartPkg::wordT  pcTargetE,
  input  logic           pcSrcE,
  input  logic           stallF,
  input  logic           stallD,
  input  logic           flushD,
  output hartPkg::wordT  pcF,
  output hartPkg::wordT  pcD,
  output hartPkg::instrT instrD
);

  hartPkg::wordT pcPlus4F;
  hartPkg::wordT pcNextF;

  // sequential fetch unless E resolved a taken branch or jump
  assign pcPlus4F = pcF + 32'd4;
  assign pcNextF  = pcSrcE ? pcTargetE : pcPlus4F;

  //////////////////////////////
  // fetch stage PC
  //////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pcF <= `HART_RESET_PC;
    end else if (!stallF) begin
      pcF <= pcNextF;
    end
  end

  //////////////////////////////
  // F-to-D register
  //////////////////////////////
  // flush turns the slot into a bubble, the hazard unit never flushes during a stall
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      instrD <= `HART_NOP;
      pcD    <= `HART_RESET_PC;
    end else if (flushD) begin
      instrD <= `HART_NOP;
      pcD    <= pcF;
    end else if (!stallD) begin
      instrD <= instrF;
      pcD    <= pcF;
    end
  end

endmodule

// ==== source/pipelinedHart.sv ====
// pipelined hart top level
// three-stage in-order RV32I core with external instruction and data memories
`timescale 1ns/1ps

module pipelinedHart (
  input  logic           clk,
  input  logic           rstN,
  // instruction port
  output hartPkg::wordT  pcF,
  input  hartPkg::instrT instrF,
  // data port
  output hartPkg::wordT  memAdrE,
  output hartPkg::wordT  writeDataE,
  output logic           memReadE,
  output logic           memWriteE,
  input  hartPkg::wordT  readDataE,
  input  logic           dataReady,
  // status
  output logic           illegalInstr
);

  //////////////////////////////
  // stage to stage signals
  //////////////////////////////
  // F to D
  hartPkg::instrT instrD;
  hartPkg::wordT  pcD;

  // E back to F
  hartPkg::wordT  pcTargetE;
  logic           pcSrcE;

  // hazard unit
  logic           memWaitE;
  logic           stallF, stallD, stallE;
  logic           flushD, flushE;

  // fetch unit with PC and F-to-D register
  ifu ifu (.*);

  // integer execution unit with decoder and register file
  ieu ieu (.*);

  // global stall and flush control
  hazard hzu (.*);

endmodule

// ==== source/regfile.sv ====
// integer register file
// 32 x 32-bit, x0 reads zero, a same-cycle write is forwarded to the D read ports
`timescale 1ns/1ps

module regfile (
  input  logic            clk,
  input  logic            rstN,
  input  hartPkg::regIdxT rs1D,
  input  hartPkg::regIdxT rs2D,
  input  hartPkg::regIdxT rdE,
  input  hartPkg::wordT   resultE,
  input  logic            regWriteE,
  output hartPkg::wordT   rd1D,
  output hartPkg::wordT   rd2D
);

  hartPkg::wordT regs [0:31];
  logic          writeLive;

  // a write to x0 is dropped
  assign writeLive = regWriteE && (rdE != 5'd0);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (writeLive) begin
      regs[rdE] <= resultE;
    end
  end

  //////////////////////////////
  // read ports with write-through
  //////////////////////////////
  // removes every data hazard between E and D
  assign rd1D = (writeLive && (rdE == rs1D)) ? resultE : regs[rs1D];
  assign rd2D = (writeLive && (rdE == rs2D)) ? resultE : regs[rs2D];

endmodule
